// File: design/pool_cfg.svh
`ifndef POOL_CFG_SVH
`define POOL_CFG_SVH

// Element width, IEEE half float
`define POOL_DATA_W 16

// Largest feature map side, must be a multiple of the window side
`define POOL_FM_SIZE_MAX 16

// Largest number of slices held in the RAM
`define POOL_DEPTH_MAX 4

// Pool window side
`define POOL_WIN 2

// Address covers depth by side squared
`define POOL_ADDR_W 10

// Size, coordinate, depth and layer number widths
`define POOL_SIZE_W 5
`define POOL_DEPTH_W 3
`define POOL_LAYER_NUM_W 4

`endif

// File: design/pool_pkg.sv
`default_nettype none

`include "pool_cfg.svh"

package pool_pkg;

	// Half float word
	// Sign in bit 15, exponent in 14:10, mantissa in 9:0
	typedef logic [`POOL_DATA_W-1:0] fp16_t;

	// Feature map RAM address
	typedef logic [`POOL_ADDR_W-1:0] fm_addr_t;

	// Layer codes seen on the layer type input
	// Codes not listed here leave the block idle
	typedef enum logic [3:0] {
		LAYER_LOAD   = 4'd0,
		LAYER_POOL   = 4'd2,
		LAYER_FINISH = 4'd9
	} layer_type_e;

endpackage

`default_nettype wire

// File: design/fm_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_cfg.svh"

module fm_ram import pool_pkg::*; (
	input  logic     clk,
	// Load port
	input  logic     wr_en_i,
	input  fm_addr_t wr_addr_i,
	input  fp16_t    wr_data_i,
	// Read request with its window tags
	input  logic     rd_en_i,
	input  fm_addr_t rd_addr_i,
	input  logic     rd_first_i,
	input  logic     rd_last_i,
	input  logic     rd_end_i,
	// Read data, one cycle later
	output logic     rd_valid_o,
	output fp16_t    rd_data_o,
	output logic     rd_first_o,
	output logic     rd_last_o,
	output logic     rd_end_o
);

	// One lane, slices stacked one after the other
	fp16_t mem [0:`POOL_DEPTH_MAX*`POOL_FM_SIZE_MAX*`POOL_FM_SIZE_MAX-1];

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
		// Registered read, holds the last word when idle
		if (rd_en_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

	// Tags ride one stage so they line up with the data
	always_ff @(posedge clk) begin
		rd_valid_o <= rd_en_i;
		rd_first_o <= rd_first_i;
		rd_last_o  <= rd_last_i;
		rd_end_o   <= rd_end_i;
	end

endmodule

`default_nettype wire

// File: design/pool_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_cfg.svh"

module pool_sequencer import pool_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  layer_type_e                  layer_type_i,
	input  logic [`POOL_LAYER_NUM_W-1:0] layer_num_i,
	input  logic [`POOL_SIZE_W-1:0]      fm_size_i,
	input  logic [`POOL_DEPTH_W-1:0]     fm_depth_i,
	input  logic                         init_done_i,
	input  logic                         result_done_i,
	output logic                         init_ready_o,
	output logic                         layer_ready_o,
	output logic                         rd_en_o,
	output fm_addr_t                     rd_addr_o,
	output logic                         rd_first_o,
	output logic                         rd_last_o,
	output logic                         rd_end_o
);

	// Window side at counter width
	localparam logic [`POOL_SIZE_W-1:0] WIN_S = `POOL_WIN;
	localparam logic [`POOL_SIZE_W-1:0] WIN_LAST = `POOL_WIN - 1;

	logic [`POOL_LAYER_NUM_W-1:0] layer_num_q;
	// Address walk active, then waiting for the final result
	logic run;
	logic busy;

	// Window position, out_row and out_col in input pixels
	logic [`POOL_DEPTH_W-1:0] slice;
	logic [`POOL_SIZE_W-1:0]  out_row;
	logic [`POOL_SIZE_W-1:0]  out_col;
	logic [`POOL_SIZE_W-1:0]  win_row;
	logic [`POOL_SIZE_W-1:0]  win_col;

	// Running bases, stepped by fm_size so no multiplier is needed
	fm_addr_t slice_base;
	fm_addr_t row_base;
	fm_addr_t win_row_base;
	fm_addr_t size_a;

	logic col_last;
	logic row_last;
	logic ocol_last;
	logic orow_last;
	logic slice_last;
	logic start;

	assign size_a = fm_addr_t'(fm_size_i);

	assign col_last   = (win_col == WIN_LAST);
	assign row_last   = (win_row == WIN_LAST);
	assign ocol_last  = ((out_col + WIN_S) == fm_size_i);
	assign orow_last  = ((out_row + WIN_S) == fm_size_i);
	assign slice_last = ((slice + 1'b1) == fm_depth_i);

	// New pool layer number after the load is done
	assign start = (layer_type_i == LAYER_POOL) && init_ready_o && (layer_num_i != layer_num_q);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			init_ready_o  <= 1'b0;
			layer_ready_o <= 1'b0;
			layer_num_q   <= '0;
			run           <= 1'b0;
			busy          <= 1'b0;
			rd_en_o       <= 1'b0;
			rd_first_o    <= 1'b0;
			rd_last_o     <= 1'b0;
			rd_end_o      <= 1'b0;
			slice         <= '0;
			out_row       <= '0;
			out_col       <= '0;
			win_row       <= '0;
			win_col       <= '0;
			slice_base    <= '0;
			row_base      <= '0;
			win_row_base  <= '0;
		end else begin
			rd_en_o    <= 1'b0;
			rd_first_o <= 1'b0;
			rd_last_o  <= 1'b0;
			rd_end_o   <= 1'b0;

			// One read per cycle, column then row inside the window
			if (run) begin
				rd_en_o    <= 1'b1;
				rd_first_o <= (win_row == '0) && (win_col == '0);
				rd_last_o  <= row_last && col_last;
				rd_end_o   <= row_last && col_last && ocol_last && orow_last && slice_last;
				if (!col_last) begin
					win_col <= win_col + 1'b1;
				end else begin
					win_col <= '0;
					if (!row_last) begin
						win_row  <= win_row + 1'b1;
						row_base <= row_base + size_a;
					end else begin
						win_row <= '0;
						if (!ocol_last) begin
							// Next window on the same output row
							out_col  <= out_col + WIN_S;
							row_base <= win_row_base;
						end else begin
							out_col <= '0;
							if (!orow_last) begin
								// Window top is the row below the last one read
								out_row      <= out_row + WIN_S;
								row_base     <= row_base + size_a;
								win_row_base <= row_base + size_a;
							end else begin
								out_row      <= '0;
								row_base     <= '0;
								win_row_base <= '0;
								if (!slice_last) begin
									// Last row start plus one row is the slice size
									slice      <= slice + 1'b1;
									slice_base <= slice_base + row_base + size_a;
								end else begin
									// Final read issued, wait for its result
									slice      <= '0;
									slice_base <= '0;
									run        <= 1'b0;
									busy       <= 1'b1;
								end
							end
						end
					end
				end
			end

			case (layer_type_i)
				LAYER_LOAD: begin
					init_ready_o  <= init_done_i;
					layer_ready_o <= init_ready_o & init_done_i;
				end
				LAYER_POOL: begin
					if (busy && result_done_i) begin
						busy          <= 1'b0;
						layer_ready_o <= 1'b1;
					end
					if (start) begin
						layer_num_q   <= layer_num_i;
						layer_ready_o <= 1'b0;
						run           <= 1'b1;
						busy          <= 1'b0;
						slice         <= '0;
						out_row       <= '0;
						out_col       <= '0;
						win_row       <= '0;
						win_col       <= '0;
						slice_base    <= '0;
						row_base      <= '0;
						win_row_base  <= '0;
					end
				end
				LAYER_FINISH: begin
					// Load state survives, the walk does not
					layer_ready_o <= 1'b0;
					run           <= 1'b0;
					busy          <= 1'b0;
					rd_en_o       <= 1'b0;
					rd_first_o    <= 1'b0;
					rd_last_o     <= 1'b0;
					rd_end_o      <= 1'b0;
					slice         <= '0;
					out_row       <= '0;
					out_col       <= '0;
					win_row       <= '0;
					win_col       <= '0;
					slice_base    <= '0;
					row_base      <= '0;
					win_row_base  <= '0;
				end
				default: begin
				end
			endcase
		end
	end

	// Address of the element under the window counters
	always_ff @(posedge clk) begin
		if (run) begin
			rd_addr_o <= slice_base + row_base + fm_addr_t'(out_col) + fm_addr_t'(win_col);
		end
	end

endmodule

`default_nettype wire

// File: design/fp16_max_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp16_max_unit import pool_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  pix_valid_i,
	input  fp16_t pix_data_i,
	input  logic  pix_first_i,
	input  logic  pix_last_i,
	input  logic  pix_end_i,
	output logic  result_valid_o,
	output fp16_t result_data_o,
	output logic  result_done_o
);

	fp16_t acc;
	fp16_t max_next;
	logic  pix_gt;
	logic  both_zero;

	// Sign magnitude compare, equal values keep the earlier element
	always_comb begin
		both_zero = (pix_data_i[14:0] == '0) && (acc[14:0] == '0);
		if (both_zero) begin
			// +0 and -0 are equal
			pix_gt = 1'b0;
		end else if (pix_data_i[15] != acc[15]) begin
			pix_gt = !pix_data_i[15];
		end else if (!pix_data_i[15]) begin
			pix_gt = pix_data_i[14:0] > acc[14:0];
		end else begin
			// Both negative, smaller magnitude is greater
			pix_gt = pix_data_i[14:0] < acc[14:0];
		end
	end

	// First element of a window loads without compare
	assign max_next = (pix_first_i || pix_gt) ? pix_data_i : acc;

	always_ff @(posedge clk) begin
		if (pix_valid_i) begin
			acc <= max_next;
		end
		if (pix_valid_i && pix_last_i) begin
			result_data_o <= max_next;
		end
	end

	// Strobes last one cycle each
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_valid_o <= 1'b0;
			result_done_o  <= 1'b0;
		end else begin
			result_valid_o <= pix_valid_i && pix_last_i;
			result_done_o  <= pix_valid_i && pix_last_i && pix_end_i;
		end
	end

endmodule

`default_nettype wire

// File: design/pool_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_cfg.svh"

module pool_layer_top import pool_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	// Layer configuration, stable during a layer
	input  layer_type_e                  layer_type_i,
	input  logic [`POOL_LAYER_NUM_W-1:0] layer_num_i,
	input  logic [`POOL_SIZE_W-1:0]      fm_size_i,
	input  logic [`POOL_DEPTH_W-1:0]     fm_depth_i,
	// Feature map load
	input  logic                         fm_wr_en_i,
	input  fm_addr_t                     fm_wr_addr_i,
	input  fp16_t                        fm_wr_data_i,
	input  logic                         init_done_i,
	// Status
	output logic                         init_ready_o,
	output logic                         layer_ready_o,
	// Pool results, no back-pressure
	output logic                         result_valid_o,
	output fp16_t                        result_data_o
);

	// Stage 1 to stage 2, address walk to RAM
	logic     rd_en;
	fm_addr_t rd_addr;
	logic     rd_first;
	logic     rd_last;
	logic     rd_end;

	// Stage 2 to stage 3, RAM data to max unit
	logic     pix_valid;
	fp16_t    pix_data;
	logic     pix_first;
	logic     pix_last;
	logic     pix_end;

	// Final window of the layer has left
	logic     result_done;

	pool_sequencer i_seq (
		.clk           (clk),
		.rst           (rst),
		.layer_type_i  (layer_type_i),
		.layer_num_i   (layer_num_i),
		.fm_size_i     (fm_size_i),
		.fm_depth_i    (fm_depth_i),
		.init_done_i   (init_done_i),
		.result_done_i (result_done),
		.init_ready_o  (init_ready_o),
		.layer_ready_o (layer_ready_o),
		.rd_en_o       (rd_en),
		.rd_addr_o     (rd_addr),
		.rd_first_o    (rd_first),
		.rd_last_o     (rd_last),
		.rd_end_o      (rd_end)
	);

	fm_ram i_ram (
		.clk        (clk),
		.wr_en_i    (fm_wr_en_i),
		.wr_addr_i  (fm_wr_addr_i),
		.wr_data_i  (fm_wr_data_i),
		.rd_en_i    (rd_en),
		.rd_addr_i  (rd_addr),
		.rd_first_i (rd_first),
		.rd_last_i  (rd_last),
		.rd_end_i   (rd_end),
		.rd_valid_o (pix_valid),
		.rd_data_o  (pix_data),
		.rd_first_o (pix_first),
		.rd_last_o  (pix_last),
		.rd_end_o   (pix_end)
	);

	fp16_max_unit i_max (
		.clk            (clk),
		.rst            (rst),
		.pix_valid_i    (pix_valid),
		.pix_data_i     (pix_data),
		.pix_first_i    (pix_first),
		.pix_last_i     (pix_last),
		.pix_end_i      (pix_end),
		.result_valid_o (result_valid_o),
		.result_data_o  (result_data_o),
		.result_done_o  (result_done)
	);

endmodule

`default_nettype wire

// File: tb/pool_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pool_checker (
	input logic clk,
	input logic rst,
	input logic init_ready_i,
	input logic layer_ready_i,
	input logic result_valid_i
);

	// Sticky flags, one per rule
	logic strobe_err  = 1'b0;
	logic overlap_err = 1'b0;
	logic ready_err   = 1'b0;
	logic failed;

	assign failed = strobe_err | overlap_err | ready_err;

	// A window takes POOL_WIN squared reads, so two strobes never touch
	a_strobe_gap: assert property (@(posedge clk) disable iff (!rst)
		result_valid_i |=> !result_valid_i)
		else begin
			strobe_err = 1'b1;
			$error("result strobe high in two cycles in a row");
		end

	// Ready only comes back after the final result has left
	a_ready_vs_result: assert property (@(posedge clk) disable iff (!rst)
		!(layer_ready_i && result_valid_i))
		else begin
			overlap_err = 1'b1;
			$error("layer ready and result strobe high together");
		end

	// Layer ready needs a finished load
	a_ready_needs_init: assert property (@(posedge clk) disable iff (!rst)
		!(layer_ready_i && !init_ready_i))
		else begin
			ready_err = 1'b1;
			$error("layer ready high while init ready is low");
		end

endmodule

bind pool_layer_top pool_checker i_checker (
	.clk            (clk),
	.rst            (rst),
	.init_ready_i   (init_ready_o),
	.layer_ready_i  (layer_ready_o),
	.result_valid_i (result_valid_o)
);

`default_nettype wire

// File: tb/tb_pool_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pool_cfg.svh"

module tb_pool_layer import pool_pkg::*; ();

	localparam int WIN = `POOL_WIN;
	localparam int MAP_WORDS = `POOL_DEPTH_MAX * `POOL_FM_SIZE_MAX * `POOL_FM_SIZE_MAX;

	logic                         clk;
	logic                         rst;
	layer_type_e                  layer_type;
	logic [`POOL_LAYER_NUM_W-1:0] layer_num;
	logic [`POOL_SIZE_W-1:0]      fm_size;
	logic [`POOL_DEPTH_W-1:0]     fm_depth;
	logic                         fm_wr_en;
	fm_addr_t                     fm_wr_addr;
	fp16_t                        fm_wr_data;
	logic                         init_done;
	logic                         init_ready;
	logic                         layer_ready;
	logic                         result_valid;
	fp16_t                        result_data;

	// Copy of the RAM contents and the results still to come
	fp16_t fm_model [0:MAP_WORDS-1];
	fp16_t exp_q [$];

	pool_layer_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.layer_type_i   (layer_type),
		.layer_num_i    (layer_num),
		.fm_size_i      (fm_size),
		.fm_depth_i     (fm_depth),
		.fm_wr_en_i     (fm_wr_en),
		.fm_wr_addr_i   (fm_wr_addr),
		.fm_wr_data_i   (fm_wr_data),
		.init_done_i    (init_done),
		.init_ready_o   (init_ready),
		.layer_ready_o  (layer_ready),
		.result_valid_o (result_valid),
		.result_data_o  (result_data)
	);

	always #4 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Half floats ordered on a signed line, so +0 and -0 tie
	function automatic bit fp16_greater(input fp16_t a, input fp16_t b);
		int ka;
		int kb;
		ka = a[15] ? -int'(a[14:0]) : int'(a[14:0]);
		kb = b[15] ? -int'(b[14:0]) : int'(b[14:0]);
		return ka > kb;
	endfunction

	// Finite values only, with some ties and signed zeros mixed in
	function automatic fp16_t random_half();
		logic [31:0] r;
		fp16_t h;
		r = $urandom;
		h = r[15:0];
		if (r[31:29] == 3'd0) begin
			case (r[17:16])
				2'd0: h = 16'h0000;
				2'd1: h = 16'h8000;
				2'd2: h = 16'h3c00;
				default: h = 16'hbc00;
			endcase
		end else if (h[14:10] == 5'h1f) begin
			h[14:10] = {1'b0, r[23:20]};
		end
		return h;
	endfunction

	// Slice, output row, output column, then row by row inside the window
	function automatic void compute_expected(input int size, input int depth);
		fp16_t best;
		fp16_t v;
		int base;
		for (int s = 0; s < depth; s++) begin
			for (int r = 0; r < size; r += WIN) begin
				for (int c = 0; c < size; c += WIN) begin
					base = s * size * size + r * size + c;
					best = fm_model[base];
					for (int wr = 0; wr < WIN; wr++) begin
						for (int wc = 0; wc < WIN; wc++) begin
							v = fm_model[base + wr * size + wc];
							if (fp16_greater(v, best)) begin
								best = v;
							end
						end
					end
					exp_q.push_back(best);
				end
			end
		end
	endfunction

	// Mixed, all zero, all negative and mixed windows
	task automatic load_directed_map();
		fp16_t tbl [0:15];
		tbl = '{16'h3c00, 16'hc000, 16'h8000, 16'h0000,
			16'h0000, 16'hbc00, 16'h8000, 16'h0000,
			16'hc400, 16'hc200, 16'h4500, 16'hc500,
			16'hc600, 16'hc100, 16'h0001, 16'h7bff};
		for (int a = 0; a < 16; a++) begin
			fm_model[a] = tbl[a];
		end
	endtask

	// Writes the model map, then raises init_done and checks the ready timing
	task automatic load_feature_map(input int size, input int depth);
		@(posedge clk);
		layer_type <= LAYER_LOAD;
		init_done  <= 1'b0;
		fm_size    <= `POOL_SIZE_W'(size);
		fm_depth   <= `POOL_DEPTH_W'(depth);
		for (int a = 0; a < size * size * depth; a++) begin
			@(posedge clk);
			fm_wr_en   <= 1'b1;
			fm_wr_addr <= fm_addr_t'(a);
			fm_wr_data <= fm_model[a];
		end
		@(posedge clk);
		fm_wr_en  <= 1'b0;
		init_done <= 1'b1;
		@(posedge clk);
		check("init_ready_latency", 32'd0, 32'(init_ready));
		@(posedge clk);
		check("init_ready_rise", 32'd1, 32'(init_ready));
		check("layer_ready_after_init", 32'd0, 32'(layer_ready));
		@(posedge clk);
		check("layer_ready_rise", 32'd1, 32'(layer_ready));
	endtask

	// New layer number, then collect results until layer ready comes back
	task automatic run_pool_layer(input string name, input int n_exp);
		int got;
		int cyc;
		int last_cyc;
		fp16_t exp_val;
		got = 0;
		cyc = 0;
		last_cyc = 0;
		@(posedge clk);
		layer_type <= LAYER_POOL;
		layer_num  <= layer_num + 1'b1;
		// Start seen on the next edge, ready low after it
		@(posedge clk);
		@(posedge clk);
		check({name, "_ready_fall"}, 32'd0, 32'(layer_ready));
		while (!layer_ready) begin
			if (cyc > n_exp * WIN * WIN + 64) begin
				fail_run({"timeout waiting for layer ready at the end of layer ", name});
			end
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					fail_run({"result strobe with no expected value left in ", name});
				end
				exp_val = exp_q.pop_front();
				check({name, "_data"}, 32'(exp_val), 32'(result_data));
				if (got > 0) begin
					check({name, "_spacing"}, WIN * WIN, cyc - last_cyc);
				end
				last_cyc = cyc;
				got++;
			end
			@(posedge clk);
			cyc++;
		end
		// Ready must not come back before the last result
		check({name, "_count"}, n_exp, got);
		// No extra strobes once the layer is done
		for (int i = 0; i < 12; i++) begin
			check({name, "_extra_result"}, 32'd0, 32'(result_valid));
			@(posedge clk);
		end
	endtask

	// An ignored code, then the same number again, must start nothing
	task automatic hold_same_layer_number();
		@(posedge clk);
		layer_type <= layer_type_e'(4'd5);
		@(posedge clk);
		layer_type <= LAYER_POOL;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			check("repeat_no_result", 32'd0, 32'(result_valid));
			check("repeat_ready_kept", 32'd1, 32'(layer_ready));
		end
	endtask

	initial begin
		int size;
		int depth;
		void'($urandom(32'hf60dcb9f));
		clk        = 1'b0;
		rst        = 1'b0;
		layer_type = LAYER_LOAD;
		layer_num  = '0;
		fm_size    = '0;
		fm_depth   = '0;
		fm_wr_en   = 1'b0;
		fm_wr_addr = '0;
		fm_wr_data = '0;
		init_done  = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		check("reset_init_ready", 32'd0, 32'(init_ready));
		check("reset_layer_ready", 32'd0, 32'(layer_ready));
		check("reset_result_valid", 32'd0, 32'(result_valid));

		// Directed 4x4 map, one slice
		load_directed_map();
		load_feature_map(4, 1);
		exp_q.push_back(16'h3c00);
		exp_q.push_back(16'h8000);
		exp_q.push_back(16'hc100);
		exp_q.push_back(16'h7bff);
		run_pool_layer("directed", 4);
		hold_same_layer_number();

		// Finish keeps the load, a new number reruns the same map
		@(posedge clk);
		layer_type <= LAYER_FINISH;
		@(posedge clk);
		@(posedge clk);
		check("finish_ready_drop", 32'd0, 32'(layer_ready));
		check("finish_init_kept", 32'd1, 32'(init_ready));
		compute_expected(4, 1);
		run_pool_layer("after_finish", 4);

		// Random maps, the first at the largest size and depth
		for (int n = 0; n < 6; n++) begin
			size  = 16;
			depth = 4;
			if (n > 0) begin
				size  = WIN * (1 + int'($urandom_range(7)));
				depth = 1 + int'($urandom_range(3));
			end
			for (int a = 0; a < size * size * depth; a++) begin
				fm_model[a] = random_half();
			end
			load_feature_map(size, depth);
			compute_expected(size, depth);
			run_pool_layer($sformatf("random%0d", n), depth * (size / WIN) * (size / WIN));
		end

		if (!i_dut.i_checker.failed) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_run("an assertion in the bound checker failed");
		end
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/pool_pkg.sv
design/fm_ram.sv
design/pool_sequencer.sv
design/fp16_max_unit.sv
design/pool_layer_top.sv
tb/pool_checker.sv
tb/tb_pool_layer.sv

// File: Makefile
TOP := tb_pool_layer

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up in the output
all:
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
